// File: rtl/fpFormatPkg.sv
`default_nettype none

package fpFormatPkg;

    ////////////////////////////////////////
    // field widths
    ////////////////////////////////////////

    localparam int expBits     = 11;                  // double exponent field
    localparam int fracBits    = 52;                  // double fraction
    localparam int sglFracBits = 23;                  // single fraction
    localparam int extraBits   = 3;                   // round bit plus two sticky bits
    localparam int sigBits     = fracBits + extraBits; // 55 bit significand word

    // output precision
    typedef enum logic {
        fmtSingle = 1'b0,
        fmtDouble = 1'b1
    } fmtT;

    typedef logic [expBits+1:0]  fullExpT; // top two bits catch overflow and sign
    typedef logic [fracBits-1:0] fracT;

    // double view of the significand word
    typedef struct packed {
        logic [fracBits-1:0]  frac;
        logic                 round;
        logic [extraBits-2:0] sticky;
    } dblViewT;

    // single view has the 23 bit fraction on top and round/sticky below it
    typedef struct packed {
        logic [sglFracBits-1:0]         frac;
        logic                           round;
        logic [sigBits-sglFracBits-2:0] sticky; // 31 bits
    } sglViewT;

    // same 55 bits read through either format
    typedef union packed {
        dblViewT dbl;
        sglViewT sgl;
    } sigWordT;

endpackage

`default_nettype wire

// File: rtl/roundCtlPkg.sv
`default_nettype none

package roundCtlPkg;

    ////////////////////////////////////////
    // rounding modes
    ////////////////////////////////////////

    // codes 5..7 are illegal
    typedef enum logic [2:0] {
        rne = 3'd0, // nearest with ties to even
        rtz = 3'd1, // toward zero
        rdn = 3'd2, // toward -inf
        rup = 3'd3, // toward +inf
        rmm = 3'd4  // nearest with ties to max magnitude
    } roundModeT;

    ////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////

    localparam int pipeStages = 2; // bits stage then add stage

endpackage

`default_nettype wire

// File: rtl/roundStageIf.sv
`default_nettype none

// stage one to stage two payload
interface roundStageIf;
    import fpFormatPkg::*;

    logic    plus1; // round up decision
    fmtT     fmt;   // picks the increment position
    fullExpT exp;   // exponent with overflow/sign bits
    fracT    frac;  // unrounded 52 bit fraction

    modport producer (
        output plus1,
        output fmt,
        output exp,
        output frac
    );

    modport consumer (
        input plus1,
        input fmt,
        input exp,
        input frac
    );

endinterface

`default_nettype wire

// File: rtl/roundPipeCtl.sv
`default_nettype none

module roundPipeCtl (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  logic outReady,
    output logic inReady,
    output logic outValid,
    output logic ld1,
    output logic ld2
);
    import roundCtlPkg::*;

    logic full1; // stage one holds an item
    logic full2; // stage two holds an item

    // occupancy logic below is written for the two stage datapath
    if (pipeStages != 2) begin : gDepthCheck
        $error("roundPipeCtl expects a two stage pipeline");
    end

    ////////////////////////////////////////
    // handshake
    ////////////////////////////////////////

    assign outValid = full2;
    assign ld2      = full1 & (~full2 | outReady); // stage two free or draining now
    assign inReady  = ~full1 | ld2;                 // stage one free or moving on
    assign ld1      = inValid & inReady;

    // occupancy flags
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full1 <= 1'b0;
            full2 <= 1'b0;
        end else begin
            if (ld1)
                full1 <= 1'b1;        // new item in (old one left via ld2)
            else if (ld2)
                full1 <= 1'b0;        // moved down with nothing behind it
            if (ld2)
                full2 <= 1'b1;
            else if (outReady)
                full2 <= 1'b0;        // consumer took it
        end
    end

    // a stalled output stays presented until taken
    aOutHold: assert property (
        @(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid
    ) else $error("outValid dropped while outReady low");

endmodule

`default_nettype wire

// File: rtl/roundBits.sv
`default_nettype none

module roundBits (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  ld1,
    input  fpFormatPkg::sigWordT  inSig,
    input  fpFormatPkg::fullExpT  inExp,
    input  logic                  inSign,
    input  fpFormatPkg::fmtT      inFmt,
    input  roundCtlPkg::roundModeT inMode,
    roundStageIf.producer         stage
);
    import fpFormatPkg::*;
    import roundCtlPkg::*;

    logic roundBit;  // first bit below the format LSB
    logic stickyBit; // or of everything below round
    logic lsbBit;    // last kept fraction bit
    logic plus1;

    ////////////////////////////////////////
    // round / sticky / lsb extraction
    ////////////////////////////////////////

    always_comb begin
        if (inFmt == fmtDouble) begin
            roundBit  = inSig.dbl.round;
            stickyBit = |inSig.dbl.sticky;         // bits 1:0
            lsbBit    = inSig.dbl.frac[0];
        end else begin
            roundBit  = inSig.sgl.round;           // word bit 31
            stickyBit = |inSig.sgl.sticky;         // 31 low bits
            lsbBit    = inSig.sgl.frac[0];         // word bit 32
        end
    end

    ////////////////////////////////////////
    // plus-one decision
    ////////////////////////////////////////

    always_comb begin
        case (inMode)
            rne:     plus1 = roundBit & (stickyBit | lsbBit); // tie goes to even
            rtz:     plus1 = 1'b0;                          // truncate
            rdn:     plus1 = inSign & (roundBit | stickyBit);  // magnitude up when negative
            rup:     plus1 = ~inSign & (roundBit | stickyBit);
            rmm:     plus1 = roundBit;                      // tie goes away from zero
            default: plus1 = 1'b0;
        endcase
    end

    // decision and format
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage.plus1 <= 1'b0;
            stage.fmt   <= fmtDouble;
        end else if (ld1) begin
            stage.plus1 <= plus1;
            stage.fmt   <= inFmt;
        end
    end

    // exponent and fraction payload
    always_ff @(posedge clk) begin
        if (ld1) begin
            stage.exp  <= inExp;
            stage.frac <= inSig.dbl.frac; // top 52 bits for either format
        end
    end

    // upstream must never hand over an unknown mode
    aLegalMode: assert property (
        @(posedge clk) disable iff (!rstN)
        ld1 |-> inMode inside {rne, rtz, rdn, rup, rmm}
    ) else $error("illegal rounding mode %0d accepted", inMode);

endmodule

`default_nettype wire

// File: rtl/roundAdder.sv
`default_nettype none

module roundAdder (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 ld2,
    roundStageIf.consumer        stage,
    output fpFormatPkg::fullExpT outExp,
    output fpFormatPkg::fracT    outFrac
);
    import fpFormatPkg::*;

    localparam int sumBits  = expBits + 2 + fracBits;  // 65
    localparam int sglShift = fracBits - sglFracBits;  // single LSB sits at bit 29

    logic [sumBits-1:0] roundAdd; // increment at the format LSB
    logic [sumBits-1:0] sum;

    ////////////////////////////////////////
    // increment and add
    ////////////////////////////////////////

    always_comb begin
        if (stage.fmt == fmtDouble)
            roundAdd = {{(sumBits-1){1'b0}}, stage.plus1};
        else
            roundAdd = {{(sumBits-sglShift-1){1'b0}}, stage.plus1, {sglShift{1'b0}}};
    end

    // fraction overflow ripples straight into the exponent
    assign sum = {stage.exp, stage.frac} + roundAdd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outExp  <= '0;
            outFrac <= '0;
        end else if (ld2) begin
            {outExp, outFrac} <= sum;
        end
    end

    // output word must not move while no new item loads
    aHoldOut: assert property (
        @(posedge clk) disable iff (!rstN)
        !ld2 |=> $stable(outExp) && $stable(outFrac)
    ) else $error("rounded result changed without ld2");

endmodule

`default_nettype wire

// File: rtl/fpRoundTop.sv
`default_nettype none

module fpRoundTop (
    input  logic                   clk,
    input  logic                   rstN,
    // input side
    input  logic                   inValid,
    output logic                   inReady,
    input  fpFormatPkg::sigWordT   inSig,
    input  fpFormatPkg::fullExpT   inExp,
    input  logic                   inSign,
    input  fpFormatPkg::fmtT       inFmt,
    input  roundCtlPkg::roundModeT inMode,
    // output side
    output logic                   outValid,
    input  logic                   outReady,
    output fpFormatPkg::fullExpT   outExp,
    output fpFormatPkg::fracT      outFrac
);

    logic ld1; // load stage one
    logic ld2; // load stage two

    roundStageIf stageIf (); // stage one -> stage two

    // occupancy and handshake
    roundPipeCtl u0 (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .outReady (outReady),
        .inReady  (inReady),
        .outValid (outValid),
        .ld1      (ld1),
        .ld2      (ld2)
    );

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    roundBits u1 (
        .clk    (clk),
        .rstN   (rstN),
        .ld1    (ld1),
        .inSig  (inSig),
        .inExp  (inExp),
        .inSign (inSign),
        .inFmt  (inFmt),
        .inMode (inMode),
        .stage  (stageIf.producer)
    );

    roundAdder u2 (
        .clk     (clk),
        .rstN    (rstN),
        .ld2     (ld2),
        .stage   (stageIf.consumer),
        .outExp  (outExp),
        .outFrac (outFrac)
    );

endmodule

`default_nettype wire

// File: test/tbFpRound.sv
`default_nettype none

module tbFpRound;
    import fpFormatPkg::*;
    import roundCtlPkg::*;

    localparam int fieldsPerVec  = 7;               // fmt mode sign exp sig expExp expFrac
    localparam int maxVecs       = 64;
    localparam int timeoutCycles = 40 * pipeStages; // room for long random stalls

    logic      clk = 1'b0;
    logic      rstN;
    logic      inValid;
    logic      inReady;
    sigWordT   inSig;
    fullExpT   inExp;
    logic      inSign;
    fmtT       inFmt;
    roundModeT inMode;
    logic      outValid;
    logic      outReady;
    fullExpT   outExp;
    fracT      outFrac;

    logic [63:0] vecMem [0:maxVecs*fieldsPerVec-1];
    fullExpT     expExpQ[$];  // expected results in issue order
    fracT        expFracQ[$];

    integer seed = 59;
    int     numVecs;
    int     errors;
    int     passCount;
    int     gotCount;
    bit     timedOut;
    bit     runDone;

    fpRoundTop dut0 (.*);

    always #20 clk = ~clk; // 40 unit period

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic loadVectors();
        for (int a = 0; a < maxVecs*fieldsPerVec; a++)
            vecMem[a] = {8'hff, 56'(a)}; // top bit set marks words the file never wrote
        $readmemh("test/roundStimulus.txt", vecMem);
        numVecs = 0;
        while (numVecs < maxVecs && vecMem[numVecs*fieldsPerVec][63] == 1'b0)
            numVecs++;
        if (numVecs == 0)
            $display("no vectors found in test/roundStimulus.txt");
    endtask

    // valid held high with stable data until the DUT takes it
    task automatic driveVectors();
        int base;
        int waitCycles;
        @(posedge clk);
        for (int i = 0; i < numVecs && !timedOut; i++) begin
            base = i * fieldsPerVec;
            inValid <= 1'b1;
            inFmt   <= fmtT'(vecMem[base][0]);
            inMode  <= roundModeT'(vecMem[base+1][2:0]);
            inSign  <= vecMem[base+2][0];
            inExp   <= vecMem[base+3][expBits+1:0];
            inSig   <= vecMem[base+4][sigBits-1:0];
            waitCycles = 0;
            do begin
                @(negedge clk); // handshake settled mid cycle
                waitCycles++;
            end while (!inReady && waitCycles < timeoutCycles);
            if (!inReady) begin
                $display("timeout: vector %0d was never accepted", i);
                timedOut = 1'b1;
            end else begin
                expExpQ.push_back(vecMem[base+5][expBits+1:0]);
                expFracQ.push_back(vecMem[base+6][fracBits-1:0]);
                @(posedge clk); // transfer edge
            end
        end
        inValid <= 1'b0;
    endtask

    task automatic collectResults();
        int      waitCycles;
        int      errBefore;
        bit      taken;
        bit      stalled;
        fullExpT heldExp;
        fracT    heldFrac;
        while (gotCount < numVecs && !timedOut) begin
            waitCycles = 0;
            errBefore  = errors;
            taken      = 1'b0;
            stalled    = 1'b0;
            while (!taken && waitCycles < timeoutCycles) begin
                @(negedge clk);
                waitCycles++;
                if (stalled) begin // result must sit still until taken
                    checkValue("outValid under stall", outValid, 1);
                    checkValue("outExp under stall", outExp, heldExp);
                    checkValue("outFrac under stall", outFrac, heldFrac);
                end
                stalled  = outValid && !outReady;
                heldExp  = outExp;
                heldFrac = outFrac;
                taken    = outValid && outReady;
            end
            if (!taken) begin
                $display("timeout: result %0d never came out", gotCount);
                timedOut = 1'b1;
            end else if (expExpQ.size() == 0) begin
                $display("a result came out with no vector outstanding");
                errors++;
                gotCount++;
            end else begin
                checkValue("outExp", outExp, expExpQ.pop_front());
                checkValue("outFrac", outFrac, expFracQ.pop_front());
                $display("test %0d: exp %h frac %h %s", gotCount, outExp, outFrac,
                         (errors == errBefore) ? "ok" : "mismatch");
                if (errors == errBefore)
                    passCount++;
                gotCount++;
            end
        end
    endtask

    // consumer stalls about one cycle in four
    task automatic randomBackPressure();
        int cycles;
        cycles = 0;
        while (!runDone && cycles < timeoutCycles * maxVecs) begin
            @(posedge clk);
            outReady <= ({$random(seed)} % 4) != 0;
            cycles++;
        end
        outReady <= 1'b1;
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rstN     <= 1'b0;
        inValid  <= 1'b0;
        inSig    <= '0;
        inExp    <= '0;
        inSign   <= 1'b0;
        inFmt    <= fmtDouble;
        inMode   <= rne;
        outReady <= 1'b0;
        errors    = 0;
        passCount = 0;
        gotCount  = 0;
        timedOut  = 1'b0;
        runDone   = 1'b0;
        loadVectors();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("outValid after reset", outValid, 0); // both stages empty
        checkValue("inReady after reset", inReady, 1);
        fork
            driveVectors();
            begin
                collectResults();
                runDone = 1'b1;
            end
            randomBackPressure();
        join
        repeat (4) @(negedge clk);
        if (!timedOut)
            checkValue("outValid after drain", outValid, 0); // nothing duplicated
        $display("tests %0d, ok %0d, errors %0d", numVecs, passCount, errors);
        if (errors == 0 && !timedOut && numVecs > 0 && gotCount == numVecs) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/fpFormatPkg.sv
rtl/roundCtlPkg.sv
rtl/roundStageIf.sv
rtl/roundPipeCtl.sv
rtl/roundBits.sv
rtl/roundAdder.sv
rtl/fpRoundTop.sv
test/tbFpRound.sv

// File: test/roundStimulus.txt
// columns: fmt(1=double 0=single) mode sign exp sig expectedExp expectedFrac
// modes: 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm
// double, even lsb frac 8000000000002, odd lsb frac 8000000000003
1 0 0 03ff 40000000000010 03ff 8000000000002
1 0 1 03ff 40000000000011 03ff 8000000000002
1 0 0 03ff 40000000000014 03ff 8000000000002
1 0 1 03ff 4000000000001c 03ff 8000000000004
1 0 0 03ff 40000000000015 03ff 8000000000003
1 1 0 03ff 4000000000001d 03ff 8000000000003
1 1 1 03ff 40000000000014 03ff 8000000000002
1 2 0 03ff 40000000000011 03ff 8000000000002
1 2 1 03ff 40000000000011 03ff 8000000000003
1 2 1 03ff 4000000000001c 03ff 8000000000004
1 2 1 03ff 40000000000018 03ff 8000000000003
1 3 0 03ff 40000000000011 03ff 8000000000003
1 3 1 03ff 40000000000015 03ff 8000000000002
1 3 0 03ff 4000000000001c 03ff 8000000000004
1 3 0 03ff 40000000000018 03ff 8000000000003
1 4 0 03ff 40000000000014 03ff 8000000000003
1 4 0 03ff 4000000000001c 03ff 8000000000004
1 4 1 03ff 40000000000019 03ff 8000000000003
1 4 1 03ff 40000000000015 03ff 8000000000003
// single, increment at frac bit 29, low 29 frac bits pass through
0 0 0 0080 40000080000000 0080 8000010000000
0 0 1 0080 40000180000000 0080 8000050000000
0 0 0 0080 40000080000001 0080 8000030000000
0 3 0 0080 40000000000001 0080 8000020000000
0 1 0 0080 400001ffffffff 0080 800003fffffff
0 2 1 0080 40000140000000 0080 8000048000000
// all ones fraction rounding up carries into the exponent
1 3 0 03ff 7ffffffffffff9 0400 0000000000000
1 0 0 07ff 7ffffffffffffc 0800 0000000000000
1 4 1 0fff 7ffffffffffffe 1000 0000000000000
0 3 0 00fe 7fffff00000001 00ff 0000000000000
0 0 0 0400 7fffff80000000 0401 0000010000000
